// File: hw/tx_radio_pkg.sv
package tx_radio_pkg;

  // -------------------------------------------------------------------------
  // Widths with a meaning of their own
  // -------------------------------------------------------------------------

  typedef logic [31:0] samp_t;
  typedef logic [63:0] radio_time_t;
  typedef logic [19:0] ctrl_addr_t;
  typedef logic [31:0] ctrl_data_t;
  typedef logic [9:0]  port_id_t;
  typedef logic [15:0] epid_t;
  typedef logic [7:0]  err_code_t;

  // Error policy: what to discard after an error
  typedef enum logic [0:0] {
    policy_packet = 1'b0,
    policy_burst  = 1'b1
  } tx_policy_e;

  // -------------------------------------------------------------------------
  // Register map and error codes
  // -------------------------------------------------------------------------

  localparam ctrl_addr_t reg_tx_idle_value   = 20'h10;
  localparam ctrl_addr_t reg_tx_error_policy = 20'h14;
  localparam ctrl_addr_t reg_tx_err_port     = 20'h18;
  localparam ctrl_addr_t reg_tx_err_rem_port = 20'h1C;
  localparam ctrl_addr_t reg_tx_err_rem_epid = 20'h20;
  localparam ctrl_addr_t reg_tx_err_addr     = 20'h24;

  localparam err_code_t err_tx_underrun  = 8'd1;
  localparam err_code_t err_tx_late_data = 8'd2;

  // Error queue geometry
  localparam int err_queue_depth = 4;
  localparam int err_queue_aw    = $clog2(err_queue_depth);

  // -------------------------------------------------------------------------
  // Bundles
  // -------------------------------------------------------------------------

  typedef struct packed {
    logic       wr;
    logic       rd;
    ctrl_addr_t addr;
    ctrl_data_t data;
  } ctrl_req_t;

  typedef struct packed {
    logic       ack;
    ctrl_data_t data;
  } ctrl_resp_t;

  // Live configuration out of the register bank
  typedef struct packed {
    samp_t      idle_value;
    tx_policy_e policy;
    ctrl_addr_t err_addr;
    port_id_t   portid;
    epid_t      rem_epid;
    port_id_t   rem_portid;
  } tx_cfg_t;

  // Single-cycle error pulse, tstamp is the radio time of detection
  typedef struct packed {
    logic        valid;
    err_code_t   code;
    radio_time_t tstamp;
  } err_event_t;

  // Outgoing timed error write
  typedef struct packed {
    logic        wr;
    ctrl_addr_t  addr;
    ctrl_data_t  data;
    radio_time_t tstamp;
    port_id_t    portid;
    epid_t       rem_epid;
    port_id_t    rem_portid;
  } err_req_t;

  // Sample stream, everything except tready
  typedef struct packed {
    samp_t       tdata;
    logic        tlast;
    logic        tvalid;
    radio_time_t timestamp;
    logic        has_time;
    logic        eob;
  } tx_axis_t;

endpackage

// File: hw/tx_ctrl_regs.sv
`timescale 1ns/1ns

module tx_ctrl_regs
  import tx_radio_pkg::*;
(
  input  logic       radio_clk,
  input  logic       radio_rst,
  input  ctrl_req_t  s_ctrl,
  output ctrl_resp_t s_ctrl_resp,
  output tx_cfg_t    cfg
);

  // Address decode results
  logic       addr_hit;
  ctrl_data_t rd_value;

  // -------------------------------------------------------------------------
  // Address decode and read mux
  // -------------------------------------------------------------------------

  // Read values are zero-extended to the bus width
  always_comb begin
    addr_hit = 1'b1;
    rd_value = '0;
    case (s_ctrl.addr)
      reg_tx_idle_value: begin
        rd_value = ctrl_data_t'(cfg.idle_value);
      end
      reg_tx_error_policy: begin
        rd_value = ctrl_data_t'(cfg.policy);
      end
      reg_tx_err_port: begin
        rd_value = ctrl_data_t'(cfg.portid);
      end
      reg_tx_err_rem_port: begin
        rd_value = ctrl_data_t'(cfg.rem_portid);
      end
      reg_tx_err_rem_epid: begin
        rd_value = ctrl_data_t'(cfg.rem_epid);
      end
      reg_tx_err_addr: begin
        rd_value = ctrl_data_t'(cfg.err_addr);
      end
      default: begin
        // Unknown address, never acknowledged
        addr_hit = 1'b0;
      end
    endcase
  end

  // -------------------------------------------------------------------------
  // Response, one cycle after the strobe
  // -------------------------------------------------------------------------

  always_ff @(posedge radio_clk) begin
    if (radio_rst) begin
      s_ctrl_resp <= '0;
    end else begin
      s_ctrl_resp.ack  <= (s_ctrl.wr | s_ctrl.rd) & addr_hit;
      // Data only alongside a read ack, zero otherwise
      s_ctrl_resp.data <= (s_ctrl.rd & addr_hit) ? rd_value : '0;
    end
  end

  // -------------------------------------------------------------------------
  // Register writes
  // -------------------------------------------------------------------------

  always_ff @(posedge radio_clk) begin
    if (radio_rst) begin
      cfg.idle_value <= '0;
      cfg.policy     <= policy_packet;
      cfg.err_addr   <= '0;
      cfg.portid     <= '0;
      cfg.rem_epid   <= '0;
      cfg.rem_portid <= '0;
    end else if (s_ctrl.wr) begin
      case (s_ctrl.addr)
        reg_tx_idle_value:   cfg.idle_value <= samp_t'(s_ctrl.data);
        reg_tx_error_policy: begin
          // Anything but the burst code falls back to packet policy
          if (s_ctrl.data == ctrl_data_t'(policy_burst)) begin
            cfg.policy <= policy_burst;
          end else begin
            cfg.policy <= policy_packet;
          end
        end
        reg_tx_err_port:     cfg.portid     <= port_id_t'(s_ctrl.data);
        reg_tx_err_rem_port: cfg.rem_portid <= port_id_t'(s_ctrl.data);
        reg_tx_err_rem_epid: cfg.rem_epid   <= epid_t'(s_ctrl.data);
        reg_tx_err_addr:     cfg.err_addr   <= ctrl_addr_t'(s_ctrl.data);
        default: ;
      endcase
    end
  end

endmodule

// File: hw/tx_burst_sequencer.sv
`timescale 1ns/1ns

module tx_burst_sequencer
  import tx_radio_pkg::*;
(
  input  logic        radio_clk,
  input  logic        radio_rst,
  input  tx_axis_t    s_axis,
  output logic        s_axis_tready,
  input  radio_time_t radio_time,
  input  logic        radio_tx_stb,
  output samp_t       radio_tx_data,
  output logic        radio_tx_running,
  input  samp_t       idle_value,
  input  tx_policy_e  policy,
  output err_event_t  err_event
);

  typedef enum logic [1:0] {
    st_idle,
    st_time_check,
    st_transmit,
    st_drop
  } seq_state_e;

  seq_state_e state;

  // Packet framing
  logic sop;
  logic eob;
  logic cur_eob;
  logic beat;

  // Registered time comparisons
  logic time_now;
  logic time_past;

  // Drop exit decision
  logic drop_done;
  logic pkt_end;
  logic between_pkts;

  // Error pulse
  logic        err_valid;
  err_code_t   err_code;
  radio_time_t err_time;

  assign beat = s_axis.tvalid & s_axis_tready;

  // On the first word the sideband eob is live, later it is the latched one
  assign cur_eob = sop ? s_axis.eob : eob;

  // -------------------------------------------------------------------------
  // Time compare, one cycle behind radio_time
  // -------------------------------------------------------------------------

  always_ff @(posedge radio_clk) begin
    time_now  <= (radio_time == s_axis.timestamp);
    time_past <= (radio_time >  s_axis.timestamp);
  end

  // -------------------------------------------------------------------------
  // Start-of-packet and end-of-burst tracking
  // -------------------------------------------------------------------------

  always_ff @(posedge radio_clk) begin
    if (radio_rst) begin
      sop <= 1'b1;
      eob <= 1'b0;
    end else if (beat) begin
      // Single-word packets still latch their eob
      if (sop) begin
        eob <= s_axis.eob;
      end
      sop <= s_axis.tlast;
    end
  end

  // Drop ends at a packet boundary, and for burst policy only at a burst end
  assign pkt_end      = s_axis.tvalid & s_axis.tlast;
  assign between_pkts = ~s_axis.tvalid & sop;
  assign drop_done    = (pkt_end & ((policy == policy_packet) | cur_eob)) |
                        (between_pkts & ((policy == policy_packet) | eob));

  // -------------------------------------------------------------------------
  // Burst FSM
  // -------------------------------------------------------------------------

  always_ff @(posedge radio_clk) begin
    if (radio_rst) begin
      state     <= st_idle;
      err_valid <= 1'b0;
    end else begin
      err_valid <= 1'b0;
      case (state)
        st_idle: begin
          // Give the time compare a cycle to see the new header
          if (s_axis.tvalid) begin
            state <= st_time_check;
          end
        end
        st_time_check: begin
          if (!s_axis.has_time || time_now) begin
            state <= st_transmit;
          end else if (time_past) begin
            err_valid <= 1'b1;
            err_code  <= err_tx_late_data;
            err_time  <= radio_time;
            state     <= st_drop;
          end
        end
        st_transmit: begin
          if (radio_tx_stb) begin
            if (!s_axis.tvalid) begin
              // Radio wanted a sample and none was there
              err_valid <= 1'b1;
              err_code  <= err_tx_underrun;
              err_time  <= radio_time;
              state     <= st_drop;
            end else if (s_axis.tlast && cur_eob) begin
              state <= st_idle;
            end
          end
        end
        st_drop: begin
          if (drop_done) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  assign err_event = '{valid: err_valid, code: err_code, tstamp: err_time};

  // Consume on strobes while sending, flush freely while dropping
  assign s_axis_tready    = (radio_tx_stb & (state == st_transmit)) | (state == st_drop);
  assign radio_tx_running = (state == st_transmit);
  assign radio_tx_data    = (s_axis.tvalid && state == st_transmit) ? s_axis.tdata
                                                                    : idle_value;

endmodule

// File: hw/tx_error_reporter.sv
`timescale 1ns/1ns

module tx_error_reporter
  import tx_radio_pkg::*;
(
  input  logic       radio_clk,
  input  logic       radio_rst,
  input  err_event_t err_event,
  input  tx_cfg_t    cfg,
  output err_req_t   m_ctrl,
  input  logic       m_ctrl_ack
);

  typedef enum logic [0:0] {
    rep_idle,
    rep_wait_ack
  } rep_state_e;

  rep_state_e state;

  // -------------------------------------------------------------------------
  // Error queue
  // -------------------------------------------------------------------------

  err_code_t   code_mem [err_queue_depth];
  radio_time_t time_mem [err_queue_depth];

  logic [err_queue_aw-1:0] wr_ptr;
  logic [err_queue_aw-1:0] rd_ptr;
  logic [err_queue_aw:0]   count;

  logic full;
  logic empty;
  logic push;
  logic pop;

  // Request payload
  logic        req_wr;
  ctrl_addr_t  req_addr;
  ctrl_data_t  req_data;
  radio_time_t req_time;

  assign full  = (count == (err_queue_aw + 1)'(err_queue_depth));
  assign empty = (count == '0);

  // Events that arrive while full are lost
  assign push = err_event.valid & ~full;
  assign pop  = (state == rep_idle) & ~empty;

  always_ff @(posedge radio_clk) begin
    if (push) begin
      code_mem[wr_ptr] <= err_event.code;
      time_mem[wr_ptr] <= err_event.tstamp;
    end
  end

  // Pointers wrap naturally, depth is a power of two
  always_ff @(posedge radio_clk) begin
    if (radio_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
    end
  end

  // -------------------------------------------------------------------------
  // Report FSM, one write in flight at a time
  // -------------------------------------------------------------------------

  always_ff @(posedge radio_clk) begin
    if (radio_rst) begin
      state  <= rep_idle;
      req_wr <= 1'b0;
    end else begin
      req_wr <= 1'b0;
      case (state)
        rep_idle: begin
          if (pop) begin
            req_wr   <= 1'b1;
            req_addr <= cfg.err_addr;
            req_data <= ctrl_data_t'(code_mem[rd_ptr]);
            req_time <= time_mem[rd_ptr];
            state    <= rep_wait_ack;
          end
        end
        rep_wait_ack: begin
          if (m_ctrl_ack) begin
            state <= rep_idle;
          end
        end
        default: state <= rep_idle;
      endcase
    end
  end

  // Routing follows the live register values
  assign m_ctrl = '{
    wr:         req_wr,
    addr:       req_addr,
    data:       req_data,
    tstamp:     req_time,
    portid:     cfg.portid,
    rem_epid:   cfg.rem_epid,
    rem_portid: cfg.rem_portid
  };

endmodule

// File: hw/tx_radio_core.sv
`timescale 1ns/1ns

module tx_radio_core
  import tx_radio_pkg::*;
(
  input  logic        radio_clk,
  input  logic        radio_rst,

  // Register access
  input  ctrl_req_t   s_ctrl,
  output ctrl_resp_t  s_ctrl_resp,

  // Sample stream
  input  tx_axis_t    s_axis,
  output logic        s_axis_tready,

  // Radio side
  input  radio_time_t radio_time,
  input  logic        radio_tx_stb,
  output samp_t       radio_tx_data,
  output logic        radio_tx_running,

  // Error reports
  output err_req_t    m_ctrl,
  input  logic        m_ctrl_ack
);

  // Shared configuration and error pulses
  tx_cfg_t    cfg;
  err_event_t err_event;

  // -------------------------------------------------------------------------
  // Register bank
  // -------------------------------------------------------------------------

  tx_ctrl_regs tx_ctrl_regs_inst (
    .radio_clk   (radio_clk),
    .radio_rst   (radio_rst),
    .s_ctrl      (s_ctrl),
    .s_ctrl_resp (s_ctrl_resp),
    .cfg         (cfg)
  );

  // -------------------------------------------------------------------------
  // Data path and error detection
  // -------------------------------------------------------------------------

  tx_burst_sequencer tx_burst_sequencer_inst (
    .radio_clk        (radio_clk),
    .radio_rst        (radio_rst),
    .s_axis           (s_axis),
    .s_axis_tready    (s_axis_tready),
    .radio_time       (radio_time),
    .radio_tx_stb     (radio_tx_stb),
    .radio_tx_data    (radio_tx_data),
    .radio_tx_running (radio_tx_running),
    .idle_value       (cfg.idle_value),
    .policy           (cfg.policy),
    .err_event        (err_event)
  );

  // Reports carry the routing fields from the bank
  tx_error_reporter tx_error_reporter_inst (
    .radio_clk  (radio_clk),
    .radio_rst  (radio_rst),
    .err_event  (err_event),
    .cfg        (cfg),
    .m_ctrl     (m_ctrl),
    .m_ctrl_ack (m_ctrl_ack)
  );

endmodule

// File: verif/tx_radio_core_tb.sv
`timescale 1ns/1ns

module tx_radio_core_tb
  import tx_radio_pkg::*;
();

  localparam logic [31:0] seed = 32'hc7f0_32d0;
  localparam int max_pkt_len = 6;
  localparam int max_pkts    = 3;
  // 12 plain, 4 timed, 4 late, 6 underrun, 6 late with the ack held
  localparam int n_bursts        = 32;
  localparam int watchdog_cycles = 20 * n_bursts * max_pkts * max_pkt_len + 2000;

  // Burst kinds
  localparam int kind_plain    = 0;
  localparam int kind_timed    = 1;
  localparam int kind_late     = 2;
  localparam int kind_underrun = 3;

  logic        radio_clk = 1'b0;
  logic        radio_rst;
  ctrl_req_t   s_ctrl;
  ctrl_resp_t  s_ctrl_resp;
  tx_axis_t    s_axis;
  logic        s_axis_tready;
  radio_time_t radio_time;
  logic        radio_tx_stb;
  samp_t       radio_tx_data;
  logic        radio_tx_running;
  err_req_t    m_ctrl;
  logic        m_ctrl_ack;

  // One random state per process
  logic [31:0] rng;
  logic [31:0] stb_rng;
  logic [31:0] ack_rng;
  radio_time_t time_at_edge;
  int          err_count;
  int          check_count;

  // Register model
  samp_t      m_idle;
  tx_policy_e m_policy;
  ctrl_addr_t m_err_addr;
  port_id_t   m_portid;
  port_id_t   m_rem_portid;
  epid_t      m_rem_epid;

  // Expected samples, each with the earliest radio time it may leave
  samp_t       exp_data[$];
  radio_time_t exp_nb[$];
  // Expected reports, time must lie after the bound
  err_code_t   exp_code[$];
  radio_time_t exp_bound[$];

  // Ack responder
  logic ack_hold;
  logic ack_pending;
  int   ack_wait;
  int   held_errs;

  tx_radio_core tx_radio_core_inst (
    .radio_clk        (radio_clk),
    .radio_rst        (radio_rst),
    .s_ctrl           (s_ctrl),
    .s_ctrl_resp      (s_ctrl_resp),
    .s_axis           (s_axis),
    .s_axis_tready    (s_axis_tready),
    .radio_time       (radio_time),
    .radio_tx_stb     (radio_tx_stb),
    .radio_tx_data    (radio_tx_data),
    .radio_tx_running (radio_tx_running),
    .m_ctrl           (m_ctrl),
    .m_ctrl_ack       (m_ctrl_ack)
  );

  always #10 radio_clk = ~radio_clk;

  // -------------------------------------------------------------------------
  // Helpers
  // -------------------------------------------------------------------------

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] rand_word();
    rng = xorshift32(rng);
    return rng;
  endfunction

  // Uniform-ish pick in 0 .. n-1
  function automatic int pick(input int n);
    rng = xorshift32(rng);
    return int'(rng % 32'(n));
  endfunction

  task automatic compare(input logic [63:0] actual, input logic [63:0] expected,
                         input string what);
    check_count++;
    if (actual !== expected) begin
      err_count++;
      $display("Error at %0t ns: %s, got 0x%0h, expected 0x%0h", $time, what, actual, expected);
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge radio_clk);
      #2;
    end
  endtask

  // Wait until the DUT and the ack responder have nothing left outstanding
  task automatic drain();
    while (exp_data.size() != 0 || exp_code.size() != 0 || ack_pending) begin
      @(posedge radio_clk);
    end
    #2;
  endtask

  // -------------------------------------------------------------------------
  // Register access and model
  // -------------------------------------------------------------------------

  function automatic ctrl_addr_t reg_addr(input int idx);
    case (idx)
      0:       return reg_tx_idle_value;
      1:       return reg_tx_error_policy;
      2:       return reg_tx_err_port;
      3:       return reg_tx_err_rem_port;
      4:       return reg_tx_err_rem_epid;
      default: return reg_tx_err_addr;
    endcase
  endfunction

  function automatic ctrl_data_t model_read(input ctrl_addr_t addr);
    case (addr)
      reg_tx_idle_value:   return m_idle;
      reg_tx_error_policy: return ctrl_data_t'(m_policy);
      reg_tx_err_port:     return ctrl_data_t'(m_portid);
      reg_tx_err_rem_port: return ctrl_data_t'(m_rem_portid);
      reg_tx_err_rem_epid: return ctrl_data_t'(m_rem_epid);
      reg_tx_err_addr:     return ctrl_data_t'(m_err_addr);
      default:             return '0;
    endcase
  endfunction

  task automatic model_write(input ctrl_addr_t addr, input ctrl_data_t data);
    case (addr)
      reg_tx_idle_value:   m_idle = data;
      // Only the burst code is legal besides packet
      reg_tx_error_policy: m_policy = (data == 32'd1) ? policy_burst : policy_packet;
      reg_tx_err_port:     m_portid = data[9:0];
      reg_tx_err_rem_port: m_rem_portid = data[9:0];
      reg_tx_err_rem_epid: m_rem_epid = data[15:0];
      reg_tx_err_addr:     m_err_addr = data[19:0];
      default: ;
    endcase
  endtask

  // One strobe, response sampled a cycle later
  task automatic reg_access(input logic is_wr, input ctrl_addr_t addr, input ctrl_data_t data,
                            output logic ack, output ctrl_data_t rdata);
    s_ctrl = '{wr: is_wr, rd: !is_wr, addr: addr, data: data};
    @(posedge radio_clk);
    #2;
    s_ctrl = '0;
    ack   = s_ctrl_resp.ack;
    rdata = s_ctrl_resp.data;
  endtask

  task automatic reg_write(input ctrl_addr_t addr, input ctrl_data_t data, input logic known);
    logic       ack;
    ctrl_data_t rdata;
    reg_access(1'b1, addr, data, ack, rdata);
    compare(ack, known, "register write ack");
    if (known) begin
      model_write(addr, data);
    end
  endtask

  task automatic reg_read(input ctrl_addr_t addr, input logic known);
    logic       ack;
    ctrl_data_t rdata;
    reg_access(1'b0, addr, 32'h0, ack, rdata);
    compare(ack, known, "register read ack");
    compare(rdata, known ? model_read(addr) : 32'h0, "register read data");
  endtask

  // -------------------------------------------------------------------------
  // Stream stimulus
  // -------------------------------------------------------------------------

  task automatic expect_report(input err_code_t code, input radio_time_t bound);
    // Ack held: one write in flight plus a full queue, the rest are lost
    if (!ack_hold || held_errs <= err_queue_depth) begin
      exp_code.push_back(code);
      exp_bound.push_back(bound);
    end
    if (ack_hold) begin
      held_errs++;
    end
  endtask

  // Hold the current word until a cycle with tready
  task automatic wait_taken();
    logic taken;
    taken = 1'b0;
    while (!taken) begin
      @(negedge radio_clk);
      taken = s_axis_tready;
      @(posedge radio_clk);
      #2;
    end
  endtask

  task automatic send_burst(input int kind);
    int          n_pkts;
    int          len;
    int          cut_pkt;
    int          cut_word;
    int          p;
    int          i;
    logic        dropping;
    logic        timed;
    radio_time_t ts;
    samp_t       w;
    timed    = (kind == kind_timed) || (kind == kind_late);
    n_pkts   = timed ? 1 : 1 + pick(max_pkts);
    cut_pkt  = pick(n_pkts);
    cut_word = 1 + pick(max_pkt_len - 1);
    dropping = 1'b0;
    for (p = 0; p < n_pkts; p++) begin
      len = 1 + pick(max_pkt_len);
      // Cut point strictly inside the packet
      if (kind == kind_underrun && p == cut_pkt) begin
        len = cut_word + 1 + pick(2);
      end
      ts = '0;
      if (kind == kind_timed) begin
        ts = time_at_edge + 20 + pick(40);
      end
      if (kind == kind_late) begin
        ts = time_at_edge - 5 - pick(40);
        expect_report(err_tx_late_data, ts);
        dropping = 1'b1;
      end
      for (i = 0; i < len; i++) begin
        if (kind == kind_underrun && p == cut_pkt && i == cut_word) begin
          // Starve the radio until the sequencer gives up
          s_axis.tvalid = 1'b0;
          expect_report(err_tx_underrun, time_at_edge);
          do begin
            @(negedge radio_clk);
          end while (radio_tx_running);
          @(posedge radio_clk);
          #2;
          dropping = 1'b1;
        end
        w = rand_word();
        s_axis = '{tdata: w, tlast: (i == len - 1), tvalid: 1'b1, timestamp: ts,
                   has_time: timed, eob: (p == n_pkts - 1)};
        if (!dropping) begin
          exp_data.push_back(w);
          exp_nb.push_back(ts);
        end
        wait_taken();
      end
      // Packet policy resumes with the next packet
      if (m_policy == policy_packet) begin
        dropping = 1'b0;
      end
    end
    s_axis = '0;
  endtask

  // -------------------------------------------------------------------------
  // Radio time, strobe and monitors
  // -------------------------------------------------------------------------

  always @(posedge radio_clk) begin
    time_at_edge = radio_time;
    #2;
    radio_time = radio_time + 1;
    stb_rng = xorshift32(stb_rng);
    radio_tx_stb = (stb_rng[5:4] != 2'b00);
  end

  // Everything is stable at the falling edge
  always @(negedge radio_clk) begin
    if (!radio_rst) begin
      if (!radio_tx_running) begin
        compare(radio_tx_data, m_idle, "idle value on radio_tx_data");
      end
      if (s_axis.tvalid && s_axis_tready && radio_tx_running) begin
        compare(radio_tx_stb, 1'b1, "sample taken without a strobe");
        if (exp_data.size() == 0) begin
          err_count++;
          $display("Error at %0t ns: sample 0x%0h sent while none was expected",
                   $time, radio_tx_data);
        end else begin
          compare(radio_tx_data, exp_data.pop_front(), "sample on radio_tx_data");
          compare(radio_time >= exp_nb.pop_front(), 1'b1, "timed sample left early");
        end
      end
    end
  end

  task automatic check_report();
    if (exp_code.size() == 0) begin
      err_count++;
      $display("Error at %0t ns: error report with code %0d sent while none was expected",
               $time, m_ctrl.data);
    end else begin
      compare(m_ctrl.data, exp_code.pop_front(), "report code");
      compare(m_ctrl.tstamp > exp_bound.pop_front(), 1'b1, "report time after its cause");
      compare(m_ctrl.addr, m_err_addr, "report address");
      compare(m_ctrl.portid, m_portid, "report port id");
      compare(m_ctrl.rem_epid, m_rem_epid, "report remote endpoint");
      compare(m_ctrl.rem_portid, m_rem_portid, "report remote port");
    end
  endtask

  // Ack each report after 0 to 6 cycles, or not at all while held
  always @(posedge radio_clk) begin
    #2;
    m_ctrl_ack = 1'b0;
    if (m_ctrl.wr) begin
      compare(ack_pending, 1'b0, "error write issued before the previous ack");
      check_report();
      ack_pending = 1'b1;
      ack_rng = xorshift32(ack_rng);
      ack_wait = int'(ack_rng % 32'd7);
    end
    if (ack_pending && !ack_hold) begin
      if (ack_wait == 0) begin
        m_ctrl_ack = 1'b1;
        ack_pending = 1'b0;
      end else begin
        ack_wait--;
      end
    end
  end

  initial begin
    repeat (watchdog_cycles) @(posedge radio_clk);
    $display("Timeout: the run did not complete within %0d cycles", watchdog_cycles);
    $display("Simulation finished: FAIL");
    $finish;
  end

  // -------------------------------------------------------------------------
  // Test sequence
  // -------------------------------------------------------------------------

  initial begin
    int         sel;
    ctrl_addr_t addr;
    ctrl_data_t data;
    rng = seed;
    stb_rng = seed ^ 32'h5a5a_0001;
    ack_rng = seed ^ 32'h0f0f_0002;
    radio_rst = 1'b1;
    s_ctrl = '0;
    s_axis = '0;
    radio_time = 64'd1000;
    radio_tx_stb = 1'b0;
    m_ctrl_ack = 1'b0;
    err_count = 0;
    check_count = 0;
    ack_hold = 1'b0;
    ack_pending = 1'b0;
    ack_wait = 0;
    held_errs = 0;
    m_idle = '0;
    m_policy = policy_packet;
    m_err_addr = '0;
    m_portid = '0;
    m_rem_portid = '0;
    m_rem_epid = '0;

    repeat (5) @(posedge radio_clk);
    #2;
    radio_rst = 1'b0;
    compare(s_ctrl_resp.ack, 1'b0, "ack after reset");
    compare(m_ctrl.wr, 1'b0, "report write after reset");
    compare(s_axis_tready, 1'b0, "tready after reset");
    compare(radio_tx_running, 1'b0, "running after reset");

    // Random register traffic, unknown addresses sit above the map
    repeat (40) begin
      sel = pick(7);
      data = rand_word();
      if (sel == 1 && pick(2) == 0) begin
        data = ctrl_data_t'(pick(2));
      end
      if (sel == 6) begin
        addr = 20'h40 + ctrl_addr_t'(pick(256) * 4);
        reg_write(addr, data, 1'b0);
        reg_read(addr, 1'b0);
      end else begin
        reg_write(reg_addr(sel), data, 1'b1);
        reg_read(reg_addr(sel), 1'b1);
      end
    end

    // Fixed routing for the stream phases
    for (sel = 0; sel < 6; sel++) begin
      reg_write(reg_addr(sel), (sel == 1) ? 32'd0 : rand_word(), 1'b1);
    end

    repeat (12) begin
      send_burst(kind_plain);
      idle_cycles(pick(4));
    end
    repeat (4) begin
      send_burst(kind_timed);
      send_burst(kind_late);
      idle_cycles(pick(4));
    end
    repeat (3) begin
      send_burst(kind_underrun);
    end
    reg_write(reg_tx_error_policy, 32'd1, 1'b1);
    repeat (3) begin
      send_burst(kind_underrun);
    end
    reg_write(reg_tx_error_policy, 32'd0, 1'b1);

    // Back-to-back errors against a stalled ack
    drain();
    @(negedge radio_clk);
    ack_hold = 1'b1;
    held_errs = 0;
    @(posedge radio_clk);
    #2;
    repeat (6) begin
      send_burst(kind_late);
    end
    idle_cycles(30);
    @(negedge radio_clk);
    ack_hold = 1'b0;
    @(posedge radio_clk);
    #2;
    drain();
    idle_cycles(20);

    $display("Checks run: %0d, errors: %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: compile.f
hw/tx_radio_pkg.sv
hw/tx_ctrl_regs.sv
hw/tx_burst_sequencer.sv
hw/tx_error_reporter.sv
hw/tx_radio_core.sv
verif/tx_radio_core_tb.sv

// File: Bender.yml
package:
  name: tx_radio

sources:
  - files:
      - hw/tx_radio_pkg.sv
      - hw/tx_ctrl_regs.sv
      - hw/tx_burst_sequencer.sv
      - hw/tx_error_reporter.sv
      - hw/tx_radio_core.sv
  - target: simulation
    files:
      - verif/tx_radio_core_tb.sv
